// File: src/digit_video_settings.svh
`ifndef DIGIT_VIDEO_SETTINGS_SVH
`define DIGIT_VIDEO_SETTINGS_SVH

// Horizontal timing in clock cycles.
// A line runs display, front porch, sync, back porch.
`define H_DISPLAY 256
`define H_BACK    23
`define H_FRONT   7
`define H_SYNC    23
`define H_TOTAL   309

// Vertical timing in lines.
// A frame runs display, bottom porch, sync, top porch.
`define V_DISPLAY 240
`define V_TOP     5
`define V_BOTTOM  14
`define V_SYNC    3
`define V_TOTAL   262

// Number of lit rows in a glyph cell.
`define GLYPH_ROWS 5

`endif

// File: src/digit_video_pkg.sv
package digit_video_pkg;

  // phase of one raster counter, shared by both axes.
  typedef enum logic [1:0] {
    PHASE_ACTIVE,
    PHASE_FRONT,
    PHASE_SYNC,
    PHASE_BACK
  } sync_phase_e;

  typedef logic [6:0] segments_t;  // segment a is bit 6, g is bit 0.

  typedef struct packed {
    logic [8:0] hpos;
    logic [8:0] vpos;
    logic       display_on;
    logic       hsync;
    logic       vsync;
    logic       frame_start;  // one cycle at the top left corner.
  } video_pos_t;

  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic [2:0] rgb;  // blue, green, red from msb down.
  } video_out_t;

  // four decimal digits, d3 is the most significant.
  typedef struct packed {
    logic [3:0] d3;
    logic [3:0] d2;
    logic [3:0] d1;
    logic [3:0] d0;
  } bcd_count_t;

endpackage

// File: src/seven_segment_decoder.sv
`timescale 1ns/1ps

module seven_segment_decoder (
  input  logic [3:0]                digit,
  output digit_video_pkg::segments_t segments
);

  // active high, a in bit 6 through g in bit 0.
  always_comb begin
    case (digit)
      4'd0:    segments = 7'b1111110;
      4'd1:    segments = 7'b0110000;
      4'd2:    segments = 7'b1101101;
      4'd3:    segments = 7'b1111001;
      4'd4:    segments = 7'b0110011;
      4'd5:    segments = 7'b1011011;
      4'd6:    segments = 7'b1011111;
      4'd7:    segments = 7'b1110000;
      4'd8:    segments = 7'b1111111;
      4'd9:    segments = 7'b1111011;
      default: segments = 7'b0000000;  // codes above nine stay dark.
    endcase
  end

endmodule

// File: src/segments_to_bitmap.sv
`timescale 1ns/1ps
`include "digit_video_settings.svh"

module segments_to_bitmap (
  input  digit_video_pkg::segments_t segments,
  input  logic [2:0]                 glyph_row,
  output logic [4:0]                 row_bits
);

  localparam logic [4:0] BAR   = 5'b11111;
  localparam logic [4:0] LEFT  = 5'b10000;
  localparam logic [4:0] RIGHT = 5'b00001;

  // bit 4 is the leftmost column of the glyph.
  always_comb begin
    row_bits = 5'b00000;
    if (glyph_row < 3'(`GLYPH_ROWS)) begin
      case (glyph_row)
        3'd0: row_bits = (segments[6] ? BAR : 5'b0) ^
                         (segments[5] ? RIGHT : 5'b0) ^
                         (segments[1] ? LEFT : 5'b0);
        3'd1: row_bits = (segments[1] ? LEFT : 5'b0) ^
                         (segments[5] ? RIGHT : 5'b0);
        3'd2: row_bits = (segments[0] ? BAR : 5'b0) ^
                         ((segments[5] || segments[4]) ? RIGHT : 5'b0) ^
                         ((segments[2] || segments[1]) ? LEFT : 5'b0);
        3'd3: row_bits = (segments[2] ? LEFT : 5'b0) ^
                         (segments[4] ? RIGHT : 5'b0);
        default: row_bits = (segments[3] ? BAR : 5'b0) ^
                            (segments[4] ? RIGHT : 5'b0) ^
                            (segments[2] ? LEFT : 5'b0);  // bottom row, segment d.
      endcase
    end
  end

endmodule

// File: src/hvsync_generator.sv
`timescale 1ns/1ps
`include "digit_video_settings.svh"

module hvsync_generator (
  input  logic                        clk,
  input  logic                        rst_n,
  output digit_video_pkg::video_pos_t pos
);

  logic [8:0]                   h_next;
  logic [8:0]                   v_next;
  logic                         h_wrap;
  logic                         v_wrap;
  digit_video_pkg::sync_phase_e h_phase;
  digit_video_pkg::sync_phase_e v_phase;
  digit_video_pkg::video_pos_t  pos_next;

  function automatic digit_video_pkg::sync_phase_e phase_of(
    input logic [8:0]  cnt,
    input int unsigned display,
    input int unsigned front,
    input int unsigned sync
  );
    digit_video_pkg::sync_phase_e phase;
    if (cnt < display) begin
      phase = digit_video_pkg::PHASE_ACTIVE;
    end else if (cnt < display + front) begin
      phase = digit_video_pkg::PHASE_FRONT;
    end else if (cnt < display + front + sync) begin
      phase = digit_video_pkg::PHASE_SYNC;
    end else begin
      phase = digit_video_pkg::PHASE_BACK;
    end
    return phase;
  endfunction

  assign h_wrap = (pos.hpos == 9'(`H_TOTAL - 1));
  assign v_wrap = (pos.vpos == 9'(`V_TOTAL - 1));

  always_comb begin
    h_next = h_wrap ? 9'd0 : pos.hpos + 9'd1;
    v_next = pos.vpos;
    if (h_wrap) begin
      v_next = v_wrap ? 9'd0 : pos.vpos + 9'd1;
    end
    if (!rst_n) begin
      h_next = 9'd0;  // reset parks the raster on the first pixel.
      v_next = 9'd0;
    end
  end

  assign h_phase = phase_of(h_next, `H_DISPLAY, `H_FRONT, `H_SYNC);
  assign v_phase = phase_of(v_next, `V_DISPLAY, `V_BOTTOM, `V_SYNC);

  // flags are decoded from the next position so they line up with the counters.
  always_comb begin
    pos_next.hpos        = h_next;
    pos_next.vpos        = v_next;
    pos_next.display_on  = (h_phase == digit_video_pkg::PHASE_ACTIVE) &&
                           (v_phase == digit_video_pkg::PHASE_ACTIVE);
    pos_next.hsync       = (h_phase == digit_video_pkg::PHASE_SYNC);
    pos_next.vsync       = (v_phase == digit_video_pkg::PHASE_SYNC);
    pos_next.frame_start = (h_next == 9'd0) && (v_next == 9'd0);
  end

  always_ff @(posedge clk) begin
    pos <= pos_next;
  end

endmodule

// File: src/digit_frame_ctrl.sv
`timescale 1ns/1ps

module digit_frame_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        run,
  input  logic                        clear,
  input  digit_video_pkg::video_pos_t pos,
  output logic [3:0]                  digit,
  output logic [2:0]                  glyph_row,
  input  logic [4:0]                  row_bits,
  output digit_video_pkg::video_out_t video,
  output digit_video_pkg::bcd_count_t count
);

  logic [2:0]                  col_ofs;
  logic                        lit_bit;
  logic                        pixel_on;
  logic                        carry1;
  logic                        carry2;
  logic                        carry3;
  digit_video_pkg::bcd_count_t count_inc;

  function automatic logic [3:0] bcd_step(input logic [3:0] d, input logic en);
    logic [3:0] result;
    result = d;
    if (en) begin
      result = (d == 4'd9) ? 4'd0 : d + 4'd1;
    end
    return result;
  endfunction

  assign carry1 = (count.d0 == 4'd9);
  assign carry2 = carry1 && (count.d1 == 4'd9);
  assign carry3 = carry2 && (count.d2 == 4'd9);

  assign count_inc.d0 = bcd_step(count.d0, 1'b1);
  assign count_inc.d1 = bcd_step(count.d1, carry1);
  assign count_inc.d2 = bcd_step(count.d2, carry2);
  assign count_inc.d3 = bcd_step(count.d3, carry3);  // 9999 rolls over to 0000.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (pos.frame_start && run) begin
      count <= count_inc;
    end
  end

  always_comb begin
    case (pos.hpos[5:4])
      2'd0:    digit = count.d3;
      2'd1:    digit = count.d2;
      2'd2:    digit = count.d1;
      default: digit = count.d0;
    endcase
  end

  assign glyph_row = pos.vpos[3:1];
  assign col_ofs   = pos.hpos[3:1];

  // columns 0 to 2 form the gap between glyphs.
  always_comb begin
    case (col_ofs)
      3'd3:    lit_bit = row_bits[4];
      3'd4:    lit_bit = row_bits[3];
      3'd5:    lit_bit = row_bits[2];
      3'd6:    lit_bit = row_bits[1];
      3'd7:    lit_bit = row_bits[0];
      default: lit_bit = 1'b0;
    endcase
  end

  assign pixel_on = pos.display_on && lit_bit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      video <= '0;
    end else begin
      video.hsync <= pos.hsync;
      video.vsync <= pos.vsync;
      video.rgb   <= {1'b0, pixel_on, 1'b0};  // green only.
    end
  end

endmodule

// File: src/digit_video_top.sv
`timescale 1ns/1ps

module digit_video_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        run,
  input  logic                        clear,
  output digit_video_pkg::video_out_t video,
  output digit_video_pkg::bcd_count_t count
);

  digit_video_pkg::video_pos_t pos;
  digit_video_pkg::segments_t  segments;
  logic [3:0]                  digit;
  logic [2:0]                  glyph_row;
  logic [4:0]                  row_bits;

  hvsync_generator hvsync_generator_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .pos   (pos)
  );

  digit_frame_ctrl digit_frame_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .clear     (clear),
    .pos       (pos),
    .digit     (digit),
    .glyph_row (glyph_row),
    .row_bits  (row_bits),
    .video     (video),
    .count     (count)
  );

  // glyph path is combinational between the position and the pixel register.
  seven_segment_decoder seven_segment_decoder_inst (
    .digit    (digit),
    .segments (segments)
  );

  segments_to_bitmap segments_to_bitmap_inst (
    .segments  (segments),
    .glyph_row (glyph_row),
    .row_bits  (row_bits)
  );

endmodule

// File: sim/digit_video_assert.sv
`timescale 1ns/1ps
`include "digit_video_settings.svh"

module digit_video_assert (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        run,
  input logic                        clear,
  input digit_video_pkg::video_out_t video,
  input digit_video_pkg::bcd_count_t count
);

  int unsigned mh = 0;  // raster position of the pixel now on video.
  int unsigned mv = 0;
  logic        started = 1'b0;
  logic [1:0]  rst_hist = 2'b11;
  int          fail_count = 0;
  logic        m_hsync;
  logic        m_vsync;
  logic        visible;
  logic        frame_edge;

  function automatic digit_video_pkg::bcd_count_t next_count(
    input digit_video_pkg::bcd_count_t c
  );
    int unsigned value;
    digit_video_pkg::bcd_count_t r;
    value = int'(c.d3) * 1000 + int'(c.d2) * 100 + int'(c.d1) * 10 + int'(c.d0);
    value = (value + 1) % 10000;
    r.d3 = 4'(value / 1000);
    r.d2 = 4'((value / 100) % 10);
    r.d1 = 4'((value / 10) % 10);
    r.d0 = 4'(value % 10);
    return r;
  endfunction

  function automatic logic glyph_lit(
    input digit_video_pkg::bcd_count_t c,
    input int unsigned h,
    input int unsigned v
  );
    logic [3:0]  dig;
    logic [6:0]  s;
    int unsigned col;
    logic        bar;
    logic        left;
    logic        right;
    case ((h / 16) % 4)
      0:       dig = c.d3;
      1:       dig = c.d2;
      2:       dig = c.d1;
      default: dig = c.d0;
    endcase
    case (dig)  // segments a to g from the msb.
      4'd0:    s = 7'b1111110;
      4'd1:    s = 7'b0110000;
      4'd2:    s = 7'b1101101;
      4'd3:    s = 7'b1111001;
      4'd4:    s = 7'b0110011;
      4'd5:    s = 7'b1011011;
      4'd6:    s = 7'b1011111;
      4'd7:    s = 7'b1110000;
      4'd8:    s = 7'b1111111;
      4'd9:    s = 7'b1111011;
      default: s = 7'b0000000;
    endcase
    col = (h / 2) % 8;
    case ((v / 2) % 8)
      0:       {bar, left, right} = {s[6], s[1], s[5]};
      1:       {bar, left, right} = {1'b0, s[1], s[5]};
      2:       {bar, left, right} = {s[0], s[2] | s[1], s[5] | s[4]};
      3:       {bar, left, right} = {1'b0, s[2], s[4]};
      4:       {bar, left, right} = {s[3], s[2], s[4]};
      default: {bar, left, right} = 3'b000;
    endcase
    return (col >= 3) && (bar ^ (col == 3 && left) ^ (col == 7 && right));
  endfunction

  always_ff @(posedge clk) begin
    rst_hist <= {rst_hist[0], rst_n};
    if (!rst_n) begin
      started <= 1'b0;
      mh      <= 0;
      mv      <= 0;
    end else begin
      started <= 1'b1;
      if (started && mh == `H_TOTAL - 1) begin
        mh <= 0;
        mv <= (mv == `V_TOTAL - 1) ? 0 : mv + 1;
      end else if (started) begin
        mh <= mh + 1;
      end
    end
  end

  assign m_hsync    = (mh >= `H_DISPLAY + `H_FRONT) && (mh < `H_DISPLAY + `H_FRONT + `H_SYNC);
  assign m_vsync    = (mv >= `V_DISPLAY + `V_BOTTOM) && (mv < `V_DISPLAY + `V_BOTTOM + `V_SYNC);
  assign visible    = (mh < `H_DISPLAY) && (mv < `V_DISPLAY);
  assign frame_edge = started && (mh == 0) && (mv == 0);

  a_reset: assert property (@(posedge clk)
    (!rst_hist[0] || !rst_hist[1]) |-> (video == '0 && count == '0))
    else begin
      fail_count++;
      $error("FAILED at %0t: outputs not cleared around reset", $time);
    end

  a_sync: assert property (@(posedge clk)
    started |-> (video.hsync == m_hsync && video.vsync == m_vsync))
    else begin
      fail_count++;
      $error("FAILED at %0t: sync level wrong at line %0d column %0d", $time, mv, mh);
    end

  a_blank: assert property (@(posedge clk)
    started |-> (!video.rgb[2] && !video.rgb[0] &&
                 !(video.rgb[1] && (!visible || m_hsync || m_vsync))))
    else begin
      fail_count++;
      $error("FAILED at %0t: colour lit outside the green visible raster", $time);
    end

  a_bcd: assert property (@(posedge clk)
    started |-> (count.d3 <= 9 && count.d2 <= 9 && count.d1 <= 9 && count.d0 <= 9))
    else begin
      fail_count++;
      $error("FAILED at %0t: count %h is not decimal", $time, count);
    end

  a_count: assert property (@(posedge clk)
    (started && !$past(clear)) |->
      count == ((frame_edge && $past(run)) ? next_count($past(count)) : $past(count)))
    else begin
      fail_count++;
      $error("FAILED at %0t: count %h after %h", $time, count, $past(count));
    end

  a_clear: assert property (@(posedge clk)
    (started && $past(clear)) |-> count == '0)
    else begin
      fail_count++;
      $error("FAILED at %0t: count %h after clear", $time, count);
    end

  a_glyph: assert property (@(posedge clk)
    (started && visible) |-> video.rgb[1] == glyph_lit($past(count), mh, mv))
    else begin
      fail_count++;
      $error("FAILED at %0t: glyph pixel wrong at line %0d column %0d", $time, mv, mh);
    end

endmodule

bind digit_video_top digit_video_assert digit_video_assert_inst (
  .clk   (clk),
  .rst_n (rst_n),
  .run   (run),
  .clear (clear),
  .video (video),
  .count (count)
);

// File: sim/digit_video_tb.sv
`timescale 1ns/1ps

module digit_video_tb;

  localparam int CYCLE_LIMIT = 450000;  // five frames with half a frame of margin.

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        run;
  logic                        clear;
  digit_video_pkg::video_out_t video;
  digit_video_pkg::bcd_count_t count;
  int                          cycle_count = 0;
  int                          timeout_errors = 0;

  digit_video_top digit_video_top_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .clear (clear),
    .video (video),
    .count (count)
  );

  always #4 clk = ~clk;

  task automatic finish_run();
    int assert_errors;
    assert_errors = digit_video_top_inst.digit_video_assert_inst.fail_count;
    $display("error count: %0d assertion, %0d timeout", assert_errors, timeout_errors);
    if (assert_errors + timeout_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic wait_vsync_fall();
    @(negedge clk);
    while (!video.vsync) @(negedge clk);
    while (video.vsync) @(negedge clk);
  endtask

  task automatic wait_lines(input int n);
    for (int i = 0; i < n; i++) begin
      while (!video.hsync) @(negedge clk);
      while (video.hsync) @(negedge clk);
    end
  endtask

  task automatic wait_count_change();
    digit_video_pkg::bcd_count_t old;
    old = count;
    while (count == old) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the frame count did not reach its final value in %0d cycles",
               CYCLE_LIMIT);
      timeout_errors++;
      finish_run();
    end
  end

  initial begin
    rst_n = 1'b0;
    run   = 1'b0;
    clear = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    run = 1'b1;  // frames 1 and 2 count up.
    wait_count_change();
    wait_count_change();
    run = 1'b0;  // frame 3 holds.
    wait_vsync_fall();
    wait_lines(10);
    wait_lines(115);
    clear = 1'b1;  // middle of frame 4.
    @(negedge clk);
    clear = 1'b0;
    run   = 1'b1;
    wait_count_change();
    wait_count_change();
    repeat (4) @(negedge clk);
    finish_run();
  end

endmodule

// File: build.f
+incdir+src
src/digit_video_pkg.sv
src/seven_segment_decoder.sv
src/segments_to_bitmap.sv
src/hvsync_generator.sv
src/digit_frame_ctrl.sv
src/digit_video_top.sv
sim/digit_video_assert.sv
sim/digit_video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module digit_video_tb \
  -o digit_video_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/digit_video_sim +verilator+error+limit+1000000 > sim.log 2>&1 \
  || echo "simulation exited with an error status" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "simulation exited with an error status" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
